/* files.f */
source/rv_pkg.sv
source/alu.sv
source/reg_file.sv
source/instr_decode.sv
source/operand_execute.sv
source/result_writeback.sv
source/rv_core_slice.sv
dv/tb_rv_core_slice.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rv_core_slice -f files.f -o sim_tb > build.log 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
    cat build.log
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
    echo "Result: pass"
    exit 0
else
    echo "Result: pass line missing from sim.log"
    exit 1
fi

/* dv/tb_rv_core_slice.sv */
// Testbench for the RV32I slice; the issuer keeps three slots between a producer and its readers
`timescale 1ns/1ps

module tb_rv_core_slice;

    typedef struct packed {
        logic [31:0]       tag;         // Cycle count at issue
        logic              wb_valid;
        rv_pkg::reg_addr_t rd;
        rv_pkg::word_t     data;
        logic              redirect;
        rv_pkg::word_t     target;
        logic              illegal;
    } expect_t;

    logic              clk = 1'b0;
    logic              rst;
    logic              instr_valid;
    rv_pkg::word_t     instr;
    rv_pkg::word_t     pc;
    logic              wb_valid;
    rv_pkg::reg_addr_t wb_rd;
    rv_pkg::word_t     wb_data;
    logic              redirect_valid;
    rv_pkg::word_t     redirect_target;
    logic              illegal;

    rv_pkg::word_t     shadow [rv_pkg::NUM_REGS];  // Architectural register values
    expect_t           exp_q [$];
    expect_t           cur;                        // What the outputs must show this cycle
    rv_pkg::word_t     model_pc;                   // PC of the next issued instruction
    rv_pkg::reg_addr_t hist [2];                   // Registers written one and two slots back
    logic [31:0]       cycle = '0;
    logic [31:0]       slots = '0;

    rv_core_slice DUT (
        .clk             (clk),
        .rst             (rst),
        .instr_valid     (instr_valid),
        .instr           (instr),
        .pc              (pc),
        .wb_valid        (wb_valid),
        .wb_rd           (wb_rd),
        .wb_data         (wb_data),
        .redirect_valid  (redirect_valid),
        .redirect_target (redirect_target),
        .illegal         (illegal)
    );

    always #2 clk = ~clk;

    // Instruction encoders following the RV32I formats
    function automatic rv_pkg::word_t r_type(input logic [6:0] f7, input rv_pkg::reg_addr_t rs2,
        input rv_pkg::reg_addr_t rs1, input logic [2:0] f3, input rv_pkg::reg_addr_t rd,
        input rv_pkg::opcode_t op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic rv_pkg::word_t i_type(input logic [11:0] imm, input rv_pkg::reg_addr_t rs1,
        input logic [2:0] f3, input rv_pkg::reg_addr_t rd, input rv_pkg::opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv_pkg::word_t u_type(input logic [19:0] imm, input rv_pkg::reg_addr_t rd,
        input rv_pkg::opcode_t op);
        return {imm, rd, op};
    endfunction

    function automatic rv_pkg::word_t b_type(input logic [12:0] imm, input rv_pkg::reg_addr_t rs2,
        input rv_pkg::reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OPC_BRANCH};
    endfunction

    function automatic rv_pkg::word_t j_type(input logic [20:0] imm, input rv_pkg::reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OPC_JAL};
    endfunction

    // Integer result by funct3, alt selects SUB or SRA
    function automatic rv_pkg::word_t int_result(input logic [2:0] f3, input logic alt,
        input rv_pkg::word_t a, input rv_pkg::word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:
            begin
                if (alt)
                    return $signed(a) >>> b[4:0];  // Arithmetic shift copies the sign bit
                return a >> b[4:0];
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Works out the architectural effect and updates the shadow registers
    task automatic model_instr(input rv_pkg::word_t ins, input rv_pkg::word_t ipc,
        output expect_t e, output rv_pkg::word_t next_pc);
        logic [2:0]        f3;
        logic [6:0]        f7;
        rv_pkg::reg_addr_t rd;
        rv_pkg::word_t     a;
        rv_pkg::word_t     b;
        rv_pkg::word_t     imm_i;
        rv_pkg::word_t     data;
        logic              legal;
        logic              writes;
        logic              taken;
        f3     = ins[14:12];
        f7     = ins[31:25];
        rd     = ins[11:7];
        a      = shadow[ins[19:15]];
        b      = shadow[ins[24:20]];
        imm_i  = {{20{ins[31]}}, ins[31:20]};
        e      = '0;
        e.tag  = cycle;
        legal  = 1'b1;
        writes = 1'b1;
        taken  = 1'b0;
        data   = '0;
        case (ins[6:0])
            rv_pkg::OPC_OP:
            begin
                legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                data  = int_result(f3, f7[5], a, b);
            end
            rv_pkg::OPC_OP_IMM:
            begin
                if (f3 == 3'd1)
                    legal = (f7 == 7'h00);             // SLLI has no alternate form
                else if (f3 == 3'd5)
                    legal = (f7 == 7'h00) || (f7 == 7'h20);
                data = int_result(f3, f3 == 3'd5 && f7[5], a, imm_i);
            end
            rv_pkg::OPC_LUI:   data = {ins[31:12], 12'h000};
            rv_pkg::OPC_AUIPC: data = ipc + {ins[31:12], 12'h000};
            rv_pkg::OPC_JAL:
            begin
                data     = ipc + 32'd4;
                taken    = 1'b1;
                e.target = ipc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            rv_pkg::OPC_JALR:
            begin
                legal    = (f3 == 3'd0);
                data     = ipc + 32'd4;
                taken    = 1'b1;
                e.target = (a + imm_i) & ~32'd1;         // Bit 0 dropped by the ISA rule
            end
            rv_pkg::OPC_BRANCH:
            begin
                writes   = 1'b0;
                e.target = ipc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                case (f3)
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = ($signed(a) < $signed(b));
                    3'd5:    taken = ($signed(a) >= $signed(b));
                    3'd6:    taken = (a < b);
                    3'd7:    taken = (a >= b);
                    default: legal = 1'b0;
                endcase
            end
            default: legal = 1'b0;                       // Loads, stores, FENCE, SYSTEM, unknown
        endcase
        e.illegal  = !legal;
        e.redirect = legal && taken;
        e.wb_valid = legal && writes && (rd != 5'd0);    // x0 never reports a write
        e.rd       = rd;
        e.data     = data;
        if (e.wb_valid)
            shadow[rd] = data;
        next_pc = e.redirect ? e.target : ipc + 32'd4;
    endtask

    task automatic issue_idle();
        @(negedge clk);
        instr_valid = 1'b0;
        hist[1]     = hist[0];
        hist[0]     = '0;
        slots       = slots + 32'd1;
    endtask

    task automatic issue_instr(input rv_pkg::word_t ins);
        expect_t           e;
        rv_pkg::word_t     next_pc;
        rv_pkg::reg_addr_t src1;
        rv_pkg::reg_addr_t src2;
        src1 = ins[19:15];                               // Field positions checked for every format
        src2 = ins[24:20];
        while ((src1 != 5'd0 && (src1 == hist[0] || src1 == hist[1])) ||
               (src2 != 5'd0 && (src2 == hist[0] || src2 == hist[1])))
            issue_idle();
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = ins;
        pc          = model_pc;
        model_instr(ins, model_pc, e, next_pc);
        exp_q.push_back(e);
        model_pc = next_pc;
        hist[1]  = hist[0];
        hist[0]  = e.wb_valid ? e.rd : 5'd0;
        slots    = slots + 32'd1;
    endtask

    function automatic rv_pkg::word_t random_instr();
        rv_pkg::word_t   r;
        logic [2:0]      f3;
        logic [11:0]     imm;
        rv_pkg::opcode_t bad_op;
        int              kind;
        r    = $urandom;
        f3   = r[14:12];
        imm  = r[31:20];
        kind = $urandom_range(0, 9);
        case (kind)
            0, 1:
                return r_type(((f3 == 3'd0 || f3 == 3'd5) && r[25]) ? 7'h20 : 7'h00,
                              r[24:20], r[19:15], f3, r[11:7], rv_pkg::OPC_OP);
            2, 3:
            begin
                if (f3 == 3'd1)
                    imm[11:5] = 7'h00;
                else if (f3 == 3'd5)
                    imm[11:5] = r[30] ? 7'h20 : 7'h00;   // SRLI or SRAI
                return i_type(imm, r[19:15], f3, r[11:7], rv_pkg::OPC_OP_IMM);
            end
            4:  return u_type(r[31:12], r[11:7], rv_pkg::OPC_LUI);
            5:  return u_type(r[31:12], r[11:7], rv_pkg::OPC_AUIPC);
            6:  return j_type({r[31:12], 1'b0}, r[11:7]);
            7:  return i_type(imm, r[19:15], 3'd0, r[11:7], rv_pkg::OPC_JALR);
            8:
            begin
                f3 = 3'($urandom_range(0, 5));
                if (f3 > 3'd1)
                    f3 = f3 + 3'd2;                      // Skips the unassigned 010 and 011
                return b_type({r[31:20], 1'b0}, r[24:20], r[19:15], f3);
            end
            default:
            begin
                case (r[6:5])
                    2'd0:    bad_op = rv_pkg::OPC_LOAD;
                    2'd1:    bad_op = rv_pkg::OPC_STORE;
                    2'd2:    bad_op = 7'b0001111;         // FENCE
                    default: bad_op = 7'b1110011;         // SYSTEM
                endcase
                return {r[31:7], bad_op};
            end
        endcase
    endfunction

    task automatic report_mismatch(input string name, input rv_pkg::word_t expected,
        input rv_pkg::word_t actual);
        $display("ERROR time=%0t signal=%s expected=0x%08h actual=0x%08h",
                 $time, name, expected, actual);
        $display("TB FAILED");
        $fatal(1, "Output mismatch on %s", name);
    endtask

    // Moves the queue head into cur when its fixed latency is reached
    always @(negedge clk)
    begin
        if (exp_q.size() != 0 && exp_q[0].tag + 32'd3 == cycle)
            cur = exp_q.pop_front();
        else
            cur = '0;                                    // Quiet outputs between results
    end

    always @(posedge clk)
    begin
        cycle <= cycle + 32'd1;
        if (cycle > 32'd52 + 32'd3 * slots)              // 2 reset cycles, 3 per slot, 50 spare
        begin
            $display("Timeout after %0d cycles with %0d results still expected",
                     cycle, exp_q.size());
            $display("TB FAILED");
            $fatal(1, "Simulation timed out");
        end
    end

    a_wb_valid: assert property (@(posedge clk) disable iff (rst) wb_valid == cur.wb_valid)
        else report_mismatch("wb_valid", 32'($sampled(cur.wb_valid)), 32'($sampled(wb_valid)));
    a_wb_rd: assert property (@(posedge clk) disable iff (rst) cur.wb_valid |-> wb_rd == cur.rd)
        else report_mismatch("wb_rd", 32'($sampled(cur.rd)), 32'($sampled(wb_rd)));
    a_wb_data: assert property (@(posedge clk) disable iff (rst)
        cur.wb_valid |-> wb_data == cur.data)
        else report_mismatch("wb_data", $sampled(cur.data), $sampled(wb_data));
    a_redirect: assert property (@(posedge clk) disable iff (rst)
        redirect_valid == cur.redirect)
        else report_mismatch("redirect_valid", 32'($sampled(cur.redirect)),
                             32'($sampled(redirect_valid)));
    a_target: assert property (@(posedge clk) disable iff (rst)
        cur.redirect |-> redirect_target == cur.target)
        else report_mismatch("redirect_target", $sampled(cur.target), $sampled(redirect_target));
    a_illegal: assert property (@(posedge clk) disable iff (rst) illegal == cur.illegal)
        else report_mismatch("illegal", 32'($sampled(cur.illegal)), 32'($sampled(illegal)));

    initial
    begin
        void'($urandom(32'h184b));
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        model_pc    = 32'h0000_1000;
        hist[0]     = '0;
        hist[1]     = '0;
        cur         = '0;
        for (int i = 0; i < rv_pkg::NUM_REGS; i++)
            shadow[i] = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Known values first, x1 and x2 get mixed signs
        issue_instr(u_type(20'h12345, 5'd1, rv_pkg::OPC_LUI));
        issue_instr(i_type(12'h678, 5'd1, 3'd0, 5'd1, rv_pkg::OPC_OP_IMM));
        issue_instr(u_type(20'hfedcb, 5'd2, rv_pkg::OPC_LUI));
        issue_instr(i_type(12'h9a3, 5'd2, 3'd0, 5'd2, rv_pkg::OPC_OP_IMM));
        issue_instr(i_type(12'h005, 5'd0, 3'd0, 5'd3, rv_pkg::OPC_OP_IMM));
        for (int f = 0; f < 8; f++)
            issue_instr(r_type(7'h00, 5'd2, 5'd1, 3'(f), 5'(4 + f), rv_pkg::OPC_OP));
        issue_instr(r_type(7'h20, 5'd2, 5'd1, 3'd0, 5'd12, rv_pkg::OPC_OP));   // SUB
        issue_instr(r_type(7'h20, 5'd3, 5'd2, 3'd5, 5'd13, rv_pkg::OPC_OP));   // SRA
        for (int f = 0; f < 8; f++)
            issue_instr(i_type((f == 1 || f == 5) ? 12'h007 : 12'h8f3, 5'd2, 3'(f),
                               5'(14 + f), rv_pkg::OPC_OP_IMM));
        issue_instr(i_type(12'h407, 5'd2, 3'd5, 5'd22, rv_pkg::OPC_OP_IMM));   // SRAI
        issue_instr(u_type(20'h00010, 5'd23, rv_pkg::OPC_AUIPC));
        issue_instr(j_type(21'h000100, 5'd24));
        issue_instr(i_type(12'h021, 5'd1, 3'd0, 5'd25, rv_pkg::OPC_JALR));      // Odd sum
        for (int c = 0; c < 6; c++)
        begin
            issue_instr(b_type(13'h0040, 5'd2, 5'd1, (c < 2) ? 3'(c) : 3'(c + 2)));
            issue_instr(b_type(13'h1ff8, 5'd1, 5'd2, (c < 2) ? 3'(c) : 3'(c + 2)));
            issue_instr(b_type(13'h0010, 5'd1, 5'd1, (c < 2) ? 3'(c) : 3'(c + 2)));
        end
        issue_instr(i_type(12'h000, 5'd1, 3'd2, 5'd26, rv_pkg::OPC_LOAD));
        issue_instr(r_type(7'h00, 5'd2, 5'd1, 3'd2, 5'd0, rv_pkg::OPC_STORE));
        issue_instr(32'h0000_007f);                                             // Unknown opcode
        issue_instr(i_type(12'h07f, 5'd1, 3'd0, 5'd0, rv_pkg::OPC_OP_IMM));     // Write to x0
        issue_instr(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd27, rv_pkg::OPC_OP));
        issue_instr(i_type(12'h001, 5'd0, 3'd0, 5'd28, rv_pkg::OPC_OP_IMM));

        for (int n = 0; n < 200; n++)
            issue_instr(random_instr());
        issue_idle();

        repeat (3) @(negedge clk);                       // Last result reaches its check
        if (exp_q.size() != 0)
        begin
            $display("Results still expected at the end of the run");
            $display("TB FAILED");
            $fatal(1, "Expectation queue not empty");
        end
        else
        begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

/* source/rv_core_slice.sv */
// Three-stage RV32I slice with no hazard logic; a dependent instruction needs three slots after its producer
`timescale 1ns/1ps

module rv_core_slice (
    input  logic              clk,
    input  logic              rst,
    input  logic              instr_valid,
    input  rv_pkg::word_t     instr,
    input  rv_pkg::word_t     pc,
    output logic              wb_valid,
    output rv_pkg::reg_addr_t wb_rd,
    output rv_pkg::word_t     wb_data,
    output logic              redirect_valid,
    output rv_pkg::word_t     redirect_target,
    output logic              illegal
);
    rv_pkg::reg_addr_t  rs1_addr;
    rv_pkg::reg_addr_t  rs2_addr;
    rv_pkg::word_t      rs1_data;
    rv_pkg::word_t      rs2_data;
    rv_pkg::decoded_t   dec;
    rv_pkg::ex_result_t ex;
    logic               we;
    rv_pkg::reg_addr_t  waddr;
    rv_pkg::word_t      wdata;

    instr_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .dec         (dec)
    );

    reg_file u_regs (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (we),
        .waddr    (waddr),
        .wdata    (wdata)
    );

    operand_execute u_execute (
        .clk (clk),
        .rst (rst),
        .dec (dec),
        .ex  (ex)
    );

    result_writeback u_result (
        .clk             (clk),
        .rst             (rst),
        .ex              (ex),
        .we              (we),
        .waddr           (waddr),
        .wdata           (wdata),
        .wb_valid        (wb_valid),
        .wb_rd           (wb_rd),
        .wb_data         (wb_data),
        .redirect_valid  (redirect_valid),
        .redirect_target (redirect_target),
        .illegal         (illegal)
    );

endmodule

/* source/result_writeback.sv */
// Result stage; the register write happens on the same edge that raises the reported outputs
`timescale 1ns/1ps

module result_writeback (
    input  logic               clk,
    input  logic               rst,
    input  rv_pkg::ex_result_t ex,
    output logic               we,
    output rv_pkg::reg_addr_t  waddr,
    output rv_pkg::word_t      wdata,
    output logic               wb_valid,
    output rv_pkg::reg_addr_t  wb_rd,
    output rv_pkg::word_t      wb_data,
    output logic               redirect_valid,
    output rv_pkg::word_t      redirect_target,
    output logic               illegal
);
    assign we    = ex.valid && ex.reg_write;
    assign waddr = ex.rd;
    assign wdata = ex.data;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wb_valid        <= 1'b0;
            wb_rd           <= '0;
            wb_data         <= '0;
            redirect_valid  <= 1'b0;
            redirect_target <= '0;
            illegal         <= 1'b0;
        end
        else
        begin
            wb_valid       <= we;                 // One-cycle strobes
            redirect_valid <= ex.redirect;
            illegal        <= ex.illegal;
            if (we)
            begin
                wb_rd   <= ex.rd;                 // Holds the last write between strobes
                wb_data <= ex.data;
            end
            if (ex.redirect)
                redirect_target <= ex.target;
        end
    end

    // Decode drops x0 writes, so none may surface two stages later
    a_no_x0_writeback: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> wb_rd != 5'd0)
        else $error("writeback reported for x0");

endmodule

/* source/operand_execute.sv */
// Execute stage with one register on its input side; assumes the PC from the issuer is word aligned
`timescale 1ns/1ps

module operand_execute (
    input  logic               clk,
    input  logic               rst,
    input  rv_pkg::decoded_t   dec,
    output rv_pkg::ex_result_t ex
);
    rv_pkg::decoded_t dec_q;       // Stage copy, all muxing works from this
    rv_pkg::word_t    op_a;
    rv_pkg::word_t    op_b;
    rv_pkg::word_t    alu_out;
    rv_pkg::word_t    pc_plus4;
    rv_pkg::word_t    pc_target;   // Branch and JAL target
    rv_pkg::word_t    jalr_sum;
    logic             taken;
    logic             is_jump;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            dec_q <= '0;
        else
            dec_q <= dec;
    end

    always_comb
    begin
        case (dec_q.a_sel)
            rv_pkg::A_PC:   op_a = dec_q.pc;
            rv_pkg::A_ZERO: op_a = '0;
            default:        op_a = dec_q.rs1_value;
        endcase
    end

    assign op_b = dec_q.b_imm ? dec_q.imm : dec_q.rs2_value;  // Branches keep rs2 here

    alu u_alu (
        .alu_ctrl (dec_q.alu_ctrl),
        .a        (op_a),
        .b        (op_b),
        .result   (alu_out)
    );

    // SUB result for EQ and NE, compare bit in bit 0 for the rest
    always_comb
    begin
        case (dec_q.branch_cond)
            rv_pkg::BR_EQ:  taken = (alu_out == '0);
            rv_pkg::BR_NE:  taken = (alu_out != '0);
            rv_pkg::BR_LT:  taken = alu_out[0];
            rv_pkg::BR_GE:  taken = !alu_out[0];
            rv_pkg::BR_LTU: taken = alu_out[0];
            rv_pkg::BR_GEU: taken = !alu_out[0];
            default:        taken = 1'b0;
        endcase
    end

    assign pc_plus4  = dec_q.pc + 32'd4;
    assign pc_target = dec_q.pc + dec_q.imm;
    assign jalr_sum  = dec_q.rs1_value + dec_q.imm;
    assign is_jump   = (dec_q.flow == rv_pkg::FLOW_JAL) || (dec_q.flow == rv_pkg::FLOW_JALR);

    always_comb
    begin
        ex           = '0;
        ex.valid     = dec_q.valid;
        ex.illegal   = dec_q.valid && dec_q.illegal;
        ex.rd        = dec_q.rd;
        ex.reg_write = dec_q.valid && dec_q.reg_write;
        ex.data      = is_jump ? pc_plus4 : alu_out;    // Link value for jumps
        ex.redirect  = dec_q.valid && !dec_q.illegal &&
                       (is_jump || (dec_q.flow == rv_pkg::FLOW_BRANCH && taken));
        ex.target    = (dec_q.flow == rv_pkg::FLOW_JALR) ? {jalr_sum[31:1], 1'b0} : pc_target;
    end

    // B and J immediates are even, so an aligned PC keeps every target even
    a_target_aligned: assert property (@(posedge clk) disable iff (rst)
        ex.redirect |-> !ex.target[0])
        else $error("redirect target 0x%08h has bit 0 set", ex.target);

endmodule

/* source/instr_decode.sv */
// Decode stage with a combinational register file read; no hazard check, loads, stores and unknown opcodes come out illegal
`timescale 1ns/1ps

module instr_decode (
    input  logic              clk,
    input  logic              rst,
    input  logic              instr_valid,  // One instruction per high cycle
    input  rv_pkg::word_t     instr,
    input  rv_pkg::word_t     pc,
    output rv_pkg::reg_addr_t rs1_addr,
    output rv_pkg::reg_addr_t rs2_addr,
    input  rv_pkg::word_t     rs1_data,
    input  rv_pkg::word_t     rs2_data,
    output rv_pkg::decoded_t  dec
);
    rv_pkg::opcode_t   opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    rv_pkg::reg_addr_t rd;
    rv_pkg::word_t     imm_i;
    rv_pkg::word_t     imm_s;
    rv_pkg::word_t     imm_b;
    rv_pkg::word_t     imm_u;
    rv_pkg::word_t     imm_j;
    rv_pkg::decoded_t  dec_d;
    logic              legal;
    logic              writes_rd;           // The class writes rd at all

    // Maps funct3 of OP and OP-IMM to the ALU code, alt picks SUB or SRA
    function automatic rv_pkg::alu_ctrl_t alu_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  return rv_pkg::ALU_SLL;
            3'b010:  return rv_pkg::ALU_SLT;
            3'b011:  return rv_pkg::ALU_SLTU;
            3'b100:  return rv_pkg::ALU_XOR;
            3'b101:  return alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  return rv_pkg::ALU_OR;
            default: return rv_pkg::ALU_AND;
        endcase
    endfunction

    assign opcode   = instr[6:0];
    assign rd       = instr[11:7];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rs1_addr = instr[19:15];        // Read every cycle whatever the format
    assign rs2_addr = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb
    begin
        dec_d             = '0;
        dec_d.valid       = instr_valid;
        dec_d.pc          = pc;
        dec_d.rs1_value   = rs1_data;
        dec_d.rs2_value   = rs2_data;
        dec_d.rd          = rd;
        dec_d.branch_cond = funct3;
        dec_d.a_sel       = rv_pkg::A_RS1;
        dec_d.alu_ctrl    = rv_pkg::ALU_ADD;
        dec_d.flow        = rv_pkg::FLOW_NONE;
        writes_rd         = 1'b0;
        legal             = 1'b1;
        case (opcode)
            rv_pkg::OPC_OP:
            begin
                dec_d.alu_ctrl = alu_op(funct3, funct7[5]);
                writes_rd      = 1'b1;
                // Only ADD/SUB and SRL/SRA have an alternate funct7
                legal = (funct7 == 7'b0000000) ||
                        (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            rv_pkg::OPC_OP_IMM:
            begin
                dec_d.imm      = imm_i;
                dec_d.b_imm    = 1'b1;
                dec_d.alu_ctrl = alu_op(funct3, funct3 == 3'b101 && funct7[5]);  // ADDI never subtracts
                writes_rd      = 1'b1;
                if (funct3 == 3'b001)
                    legal = (funct7 == 7'b0000000);
                else if (funct3 == 3'b101)
                    legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
            end
            rv_pkg::OPC_LUI:
            begin
                dec_d.imm   = imm_u;
                dec_d.b_imm = 1'b1;
                dec_d.a_sel = rv_pkg::A_ZERO;
                writes_rd   = 1'b1;
            end
            rv_pkg::OPC_AUIPC:
            begin
                dec_d.imm   = imm_u;
                dec_d.b_imm = 1'b1;
                dec_d.a_sel = rv_pkg::A_PC;
                writes_rd   = 1'b1;
            end
            rv_pkg::OPC_JAL:
            begin
                dec_d.imm  = imm_j;
                dec_d.flow = rv_pkg::FLOW_JAL;
                writes_rd  = 1'b1;
            end
            rv_pkg::OPC_JALR:
            begin
                dec_d.imm  = imm_i;
                dec_d.flow = rv_pkg::FLOW_JALR;
                writes_rd  = 1'b1;
                legal      = (funct3 == 3'b000);
            end
            rv_pkg::OPC_BRANCH:
            begin
                dec_d.imm  = imm_b;
                dec_d.flow = rv_pkg::FLOW_BRANCH;
                // EQ and NE test a difference, the others a compare
                case (funct3[2:1])
                    2'b00:   dec_d.alu_ctrl = rv_pkg::ALU_SUB;
                    2'b10:   dec_d.alu_ctrl = rv_pkg::ALU_SLT;
                    2'b11:   dec_d.alu_ctrl = rv_pkg::ALU_SLTU;
                    default: legal = 1'b0;                 // funct3 010 and 011 are unassigned
                endcase
            end
            rv_pkg::OPC_LOAD:
            begin
                dec_d.imm = imm_i;
                legal     = 1'b0;
            end
            rv_pkg::OPC_STORE:
            begin
                dec_d.imm = imm_s;
                legal     = 1'b0;
            end
            default: legal = 1'b0;
        endcase
        dec_d.illegal   = instr_valid && !legal;
        dec_d.reg_write = instr_valid && legal && writes_rd && (rd != 5'd0);  // x0 writes drop here
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            dec <= '0;
        else
            dec <= dec_d;
    end

    // A flagged instruction must reach the result stage without a write request
    a_illegal_no_write: assert property (@(posedge clk) disable iff (rst)
        dec.illegal |-> dec.valid && !dec.reg_write)
        else $error("decode bundle is illegal but requests a register write");

endmodule

/* source/reg_file.sv */
// Register file with combinational reads and no write bypass, a same-cycle read returns the old value
`timescale 1ns/1ps

module reg_file (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data,
    input  logic              we,
    input  rv_pkg::reg_addr_t waddr,
    input  rv_pkg::word_t     wdata
);
    rv_pkg::word_t regs [rv_pkg::NUM_REGS];

    // Entry 0 is cleared by reset and never written
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < rv_pkg::NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (we && waddr != 5'd0)
        begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero regardless of the array contents
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

/* source/alu.sv */
// Combinational RV32I integer ALU; no multiply or divide, shift amounts from the low five bits of b
`timescale 1ns/1ps

module alu (
    input  rv_pkg::alu_ctrl_t alu_ctrl,
    input  rv_pkg::word_t     a,
    input  rv_pkg::word_t     b,
    output rv_pkg::word_t     result
);
    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb
    begin
        case (alu_ctrl)
            rv_pkg::ALU_ADD:  result = a + b;
            rv_pkg::ALU_SUB:  result = a - b;    // Also feeds the EQ and NE test
            rv_pkg::ALU_SLL:  result = a << shamt;
            rv_pkg::ALU_SLT:  result = {31'd0, lt_signed};
            rv_pkg::ALU_SLTU: result = {31'd0, lt_unsigned};
            rv_pkg::ALU_XOR:  result = a ^ b;
            rv_pkg::ALU_SRL:  result = a >> shamt;
            rv_pkg::ALU_SRA:  result = $signed(a) >>> shamt;
            rv_pkg::ALU_OR:   result = a | b;
            rv_pkg::ALU_AND:  result = a & b;
            // Codes 10 to 15 are unused
            default:          result = '0;
        endcase
    end

endmodule

/* source/rv_pkg.sv */
// Shared RV32I slice types and codes; no load, store, FENCE, SYSTEM or M extension encodings
package rv_pkg;

    typedef logic [31:0] word_t;        // Data word, PC or immediate
    typedef logic [4:0]  reg_addr_t;    // Register index
    typedef logic [6:0]  opcode_t;      // Major opcode field instr[6:0]
    typedef logic [3:0]  alu_ctrl_t;    // Exact ALU operation
    typedef logic [1:0]  a_sel_t;       // Source of ALU operand A
    typedef logic [1:0]  flow_t;        // Control-flow class

    localparam int NUM_REGS = 32;

    // Major opcodes that decode recognizes
    localparam opcode_t OPC_LOAD   = 7'b0000011;    // Recognized only to flag it illegal
    localparam opcode_t OPC_STORE  = 7'b0100011;    // Same, stores have no data memory here
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;

    localparam alu_ctrl_t ALU_ADD  = 4'd0;
    localparam alu_ctrl_t ALU_SUB  = 4'd1;
    localparam alu_ctrl_t ALU_SLL  = 4'd2;
    localparam alu_ctrl_t ALU_SLT  = 4'd3;
    localparam alu_ctrl_t ALU_SLTU = 4'd4;
    localparam alu_ctrl_t ALU_XOR  = 4'd5;
    localparam alu_ctrl_t ALU_SRL  = 4'd6;
    localparam alu_ctrl_t ALU_SRA  = 4'd7;
    localparam alu_ctrl_t ALU_OR   = 4'd8;
    localparam alu_ctrl_t ALU_AND  = 4'd9;

    localparam a_sel_t A_RS1  = 2'd0;
    localparam a_sel_t A_PC   = 2'd1;      // AUIPC
    localparam a_sel_t A_ZERO = 2'd2;      // LUI adds the immediate to zero

    localparam flow_t FLOW_NONE   = 2'd0;
    localparam flow_t FLOW_BRANCH = 2'd1;
    localparam flow_t FLOW_JAL    = 2'd2;
    localparam flow_t FLOW_JALR   = 2'd3;

    // Branch conditions as carried in funct3
    localparam logic [2:0] BR_EQ  = 3'b000;
    localparam logic [2:0] BR_NE  = 3'b001;
    localparam logic [2:0] BR_LT  = 3'b100;
    localparam logic [2:0] BR_GE  = 3'b101;
    localparam logic [2:0] BR_LTU = 3'b110;
    localparam logic [2:0] BR_GEU = 3'b111;

    typedef struct packed {
        logic      valid;
        logic      illegal;
        word_t     pc;
        word_t     rs1_value;
        word_t     rs2_value;
        word_t     imm;
        reg_addr_t rd;
        logic      reg_write;    // Already cleared for x0 and illegal opcodes
        alu_ctrl_t alu_ctrl;
        a_sel_t    a_sel;
        logic      b_imm;        // Operand B comes from the immediate
        flow_t     flow;
        logic [2:0] branch_cond; // Raw funct3
    } decoded_t;

    typedef struct packed {
        logic      valid;
        logic      illegal;
        reg_addr_t rd;
        logic      reg_write;
        word_t     data;
        logic      redirect;     // Taken branch or any jump
        word_t     target;
    } ex_result_t;

endpackage
